//--- hdl/cce_pkg.sv
package cce_pkg;

  // Engine geometry
  localparam int num_lce_lp      = 4;
  localparam int lce_assoc_lp    = 2;
  localparam int lce_sets_lp     = 16;
  localparam int block_bytes_lp  = 64;
  localparam int paddr_width_lp  = 32;

  // Derived widths
  localparam int lg_num_lce_lp   = $clog2(num_lce_lp);
  localparam int lg_assoc_lp     = $clog2(lce_assoc_lp);
  localparam int lg_sets_lp      = $clog2(lce_sets_lp);
  localparam int block_offset_lp = $clog2(block_bytes_lp);
  localparam int tag_width_lp    = paddr_width_lp - lg_sets_lp - block_offset_lp;

  // Address pieces
  typedef logic [paddr_width_lp-1:0] paddr_t;
  typedef logic [tag_width_lp-1:0]   tag_t;
  typedef logic [lg_sets_lp-1:0]     set_t;

  // LCE and way numbering
  typedef logic [lg_num_lce_lp-1:0]  lce_id_t;
  typedef logic [lg_assoc_lp-1:0]    way_t;
  typedef logic [num_lce_lp-1:0]     lce_vec_t;

  // MESI encoding with I at zero
  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01,
    e_coh_e = 2'b10,
    e_coh_m = 2'b11
  } coh_state_e;

  typedef enum logic {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } req_type_e;

  typedef enum logic {
    e_cmd_set_tag    = 1'b0,
    e_cmd_invalidate = 1'b1
  } lce_cmd_type_e;

  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wb = 1'b1
  } mem_cmd_type_e;

  // Request sequencer
  typedef enum logic [2:0] {
    e_seq_idle       = 3'd0,
    e_seq_lookup     = 3'd1,
    e_seq_invalidate = 3'd2,
    e_seq_writeback  = 3'd3,
    e_seq_mem_read   = 3'd4,
    e_seq_mem_wait   = 3'd5,
    e_seq_set_tag    = 3'd6
  } seq_state_e;

endpackage

//--- hdl/cce_dir.sv
`timescale 1ns/1ns

module cce_dir (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    rd_v_i,
  input  cce_pkg::set_t           set_i,
  input  logic                    wr_v_i,
  input  cce_pkg::set_t           wr_set_i,
  input  cce_pkg::lce_id_t        wr_lce_i,
  input  cce_pkg::way_t           wr_way_i,
  input  cce_pkg::tag_t           wr_tag_i,
  input  cce_pkg::coh_state_e     wr_state_i,
  input  cce_pkg::lce_vec_t       inv_v_i,
  input  cce_pkg::way_t [cce_pkg::num_lce_lp-1:0] inv_way_i,
  output cce_pkg::tag_t [cce_pkg::num_lce_lp-1:0][cce_pkg::lce_assoc_lp-1:0] tags_o,
  output cce_pkg::coh_state_e [cce_pkg::num_lce_lp-1:0][cce_pkg::lce_assoc_lp-1:0] states_o
);
  import cce_pkg::*;

  // One entry per set holds every LCE and way of that set
  tag_t [num_lce_lp-1:0][lce_assoc_lp-1:0]       tag_mem [lce_sets_lp];
  coh_state_e [num_lce_lp-1:0][lce_assoc_lp-1:0] state_mem [lce_sets_lp];

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      tag_mem[wr_set_i][wr_lce_i][wr_way_i] <= wr_tag_i;
    end
    if (rd_v_i) begin
      tags_o <= tag_mem[set_i];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < lce_sets_lp; s++) begin
        for (int l = 0; l < num_lce_lp; l++) begin
          for (int w = 0; w < lce_assoc_lp; w++) begin
            state_mem[s][l][w] <= e_coh_i;
          end
        end
      end
      for (int l = 0; l < num_lce_lp; l++) begin
        for (int w = 0; w < lce_assoc_lp; w++) begin
          states_o[l][w] <= e_coh_i;
        end
      end
    end else begin
      if (wr_v_i) begin
        // Other holders drop out, then the requester's entry lands
        for (int l = 0; l < num_lce_lp; l++) begin
          if (inv_v_i[l]) begin
            state_mem[wr_set_i][l][inv_way_i[l]] <= e_coh_i;
          end
        end
        state_mem[wr_set_i][wr_lce_i][wr_way_i] <= wr_state_i;
      end
      if (rd_v_i) begin
        states_o <= state_mem[set_i];
      end
    end
  end

endmodule

//--- hdl/cce_lru.sv
`timescale 1ns/1ns

module cce_lru (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             rd_v_i,
  input  cce_pkg::lce_id_t lce_i,
  input  cce_pkg::set_t    set_i,
  input  logic             wr_v_i,
  input  cce_pkg::lce_id_t wr_lce_i,
  input  cce_pkg::set_t    wr_set_i,
  input  cce_pkg::way_t    wr_way_i,
  output cce_pkg::way_t    victim_o
);
  import cce_pkg::*;

  // Victim way per set, one row per LCE
  way_t [lce_sets_lp-1:0] victim_mem [num_lce_lp];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int l = 0; l < num_lce_lp; l++) begin
        victim_mem[l] <= '0;
      end
      victim_o <= '0;
    end else begin
      // Two ways, so the victim is whichever way was not just filled
      if (wr_v_i) begin
        victim_mem[wr_lce_i][wr_set_i] <= ~wr_way_i;
      end
      if (rd_v_i) begin
        victim_o <= victim_mem[lce_i][set_i];
      end
    end
  end

endmodule

//--- hdl/cce_gad.sv
`timescale 1ns/1ns

module cce_gad (
  input  cce_pkg::lce_id_t    req_lce_i,
  input  cce_pkg::set_t       req_set_i,
  input  cce_pkg::tag_t       req_tag_i,
  input  cce_pkg::req_type_e  req_type_i,
  input  cce_pkg::tag_t [cce_pkg::num_lce_lp-1:0][cce_pkg::lce_assoc_lp-1:0] tags_i,
  input  cce_pkg::coh_state_e [cce_pkg::num_lce_lp-1:0][cce_pkg::lce_assoc_lp-1:0] states_i,
  input  cce_pkg::way_t       victim_i,
  output cce_pkg::way_t       way_o,
  output cce_pkg::coh_state_e next_state_o,
  output cce_pkg::lce_vec_t   inv_o,
  output cce_pkg::way_t [cce_pkg::num_lce_lp-1:0] inv_way_o,
  output logic                wb_o,
  output cce_pkg::paddr_t     wb_addr_o,
  output logic                mem_rd_o
);
  import cce_pkg::*;

  lce_vec_t              holds;
  lce_vec_t              owns;
  lce_vec_t              others;
  way_t [num_lce_lp-1:0] hit_way;
  logic                  req_hit;

  // Tag match across every LCE and way of the set
  always_comb begin
    holds = '0;
    owns  = '0;
    for (int l = 0; l < num_lce_lp; l++) begin
      hit_way[l] = '0;
      for (int w = 0; w < lce_assoc_lp; w++) begin
        if (states_i[l][w] != e_coh_i && tags_i[l][w] == req_tag_i) begin
          holds[l]   = 1'b1;
          hit_way[l] = way_t'(w);
          if (states_i[l][w] inside {e_coh_e, e_coh_m}) begin
            owns[l] = 1'b1;
          end
        end
      end
    end
  end

  assign others    = holds & ~(lce_vec_t'(1) << req_lce_i);
  assign req_hit   = holds[req_lce_i];
  assign way_o     = req_hit ? hit_way[req_lce_i] : victim_i;
  assign inv_way_o = hit_way;

  // Dirty victim goes back to memory on a miss
  assign wb_o      = !req_hit && (states_i[req_lce_i][victim_i] == e_coh_m);
  assign wb_addr_o = {tags_i[req_lce_i][victim_i], req_set_i, {block_offset_lp{1'b0}}};

  // Upgrade needs no data
  assign mem_rd_o  = !(req_type_i == e_req_wr && req_hit);

  always_comb begin
    if (req_type_i == e_req_wr) begin
      inv_o        = others;
      next_state_o = e_coh_m;
    end else if (|(owns & others)) begin
      inv_o        = owns & others;
      next_state_o = e_coh_e;
    end else if (|others) begin
      inv_o        = '0;
      next_state_o = e_coh_s;
    end else begin
      inv_o        = '0;
      next_state_o = e_coh_e;
    end
  end

endmodule

//--- hdl/cce_seq.sv
`timescale 1ns/1ns

module cce_seq (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   lce_req_v_i,
  input  cce_pkg::lce_id_t       lce_req_lce_i,
  input  cce_pkg::paddr_t        lce_req_addr_i,
  input  cce_pkg::req_type_e     lce_req_type_i,
  output logic                   lce_req_yumi_o,
  output logic                   lce_cmd_v_o,
  input  logic                   lce_cmd_ready_i,
  output cce_pkg::lce_id_t       lce_cmd_dst_o,
  output cce_pkg::lce_cmd_type_e lce_cmd_type_o,
  output cce_pkg::paddr_t        lce_cmd_addr_o,
  output cce_pkg::way_t          lce_cmd_way_o,
  output cce_pkg::coh_state_e    lce_cmd_state_o,
  output logic                   mem_cmd_v_o,
  input  logic                   mem_cmd_ready_i,
  output cce_pkg::mem_cmd_type_e mem_cmd_type_o,
  output cce_pkg::paddr_t        mem_cmd_addr_o,
  output cce_pkg::lce_id_t       mem_cmd_lce_o,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_yumi_o,
  input  cce_pkg::way_t          gad_way_i,
  input  cce_pkg::coh_state_e    gad_next_state_i,
  input  cce_pkg::lce_vec_t      gad_inv_i,
  input  cce_pkg::way_t [cce_pkg::num_lce_lp-1:0] gad_inv_way_i,
  input  logic                   gad_wb_i,
  input  cce_pkg::paddr_t        gad_wb_addr_i,
  input  logic                   gad_mem_rd_i,
  output logic                   rd_v_o,
  output cce_pkg::set_t          rd_set_o,
  output logic                   wr_v_o,
  output cce_pkg::set_t          wr_set_o,
  output cce_pkg::way_t          wr_way_o,
  output cce_pkg::coh_state_e    wr_state_o,
  output cce_pkg::lce_vec_t      wr_inv_o,
  output cce_pkg::way_t [cce_pkg::num_lce_lp-1:0] wr_inv_way_o,
  output cce_pkg::lce_id_t       req_lce_o,
  output cce_pkg::tag_t          req_tag_o,
  output cce_pkg::req_type_e     req_type_o
);
  import cce_pkg::*;

  seq_state_e            state_r;
  seq_state_e            state_n;
  lce_vec_t              inv_pend_r;
  lce_vec_t              inv_pend_n;
  lce_id_t               inv_lce;
  lce_vec_t              inv_left;

  // Request and decision payload
  lce_id_t               req_lce_r;
  paddr_t                req_addr_r;
  req_type_e             req_type_r;
  way_t                  way_r;
  coh_state_e            next_state_r;
  lce_vec_t              inv_r;
  way_t [num_lce_lp-1:0] inv_way_r;
  logic                  wb_r;
  paddr_t                wb_addr_r;
  logic                  mem_rd_r;

  function automatic seq_state_e after_inv(logic wb, logic mem_rd);
    if (wb) begin
      return e_seq_writeback;
    end else if (mem_rd) begin
      return e_seq_mem_read;
    end
    return e_seq_set_tag;
  endfunction

  // Lowest pending LCE goes first
  always_comb begin
    inv_lce = '0;
    for (int l = num_lce_lp - 1; l >= 0; l--) begin
      if (inv_pend_r[l]) begin
        inv_lce = lce_id_t'(l);
      end
    end
  end

  assign inv_left = inv_pend_r & ~(lce_vec_t'(1) << inv_lce);

  always_comb begin
    state_n         = state_r;
    inv_pend_n      = inv_pend_r;
    lce_req_yumi_o  = 1'b0;
    mem_resp_yumi_o = 1'b0;
    lce_cmd_v_o     = 1'b0;
    lce_cmd_dst_o   = req_lce_r;
    lce_cmd_type_o  = e_cmd_set_tag;
    lce_cmd_way_o   = way_r;
    lce_cmd_state_o = next_state_r;
    mem_cmd_v_o     = 1'b0;
    mem_cmd_type_o  = e_mem_rd;
    mem_cmd_addr_o  = req_addr_r;
    wr_v_o          = 1'b0;
    case (state_r)
      e_seq_idle: begin
        lce_req_yumi_o = lce_req_v_i;
        if (lce_req_v_i) begin
          state_n = e_seq_lookup;
        end
      end
      e_seq_lookup: begin
        inv_pend_n = gad_inv_i;
        state_n    = (|gad_inv_i) ? e_seq_invalidate : after_inv(gad_wb_i, gad_mem_rd_i);
      end
      e_seq_invalidate: begin
        lce_cmd_v_o     = lce_cmd_ready_i;
        lce_cmd_dst_o   = inv_lce;
        lce_cmd_type_o  = e_cmd_invalidate;
        lce_cmd_way_o   = inv_way_r[inv_lce];
        lce_cmd_state_o = e_coh_i;
        if (lce_cmd_ready_i) begin
          inv_pend_n = inv_left;
          if (inv_left == '0) begin
            state_n = after_inv(wb_r, mem_rd_r);
          end
        end
      end
      e_seq_writeback: begin
        mem_cmd_v_o    = mem_cmd_ready_i;
        mem_cmd_type_o = e_mem_wb;
        mem_cmd_addr_o = wb_addr_r;
        if (mem_cmd_ready_i) begin
          state_n = mem_rd_r ? e_seq_mem_read : e_seq_set_tag;
        end
      end
      e_seq_mem_read: begin
        mem_cmd_v_o = mem_cmd_ready_i;
        if (mem_cmd_ready_i) begin
          state_n = e_seq_mem_wait;
        end
      end
      e_seq_mem_wait: begin
        mem_resp_yumi_o = mem_resp_v_i;
        if (mem_resp_v_i) begin
          state_n = e_seq_set_tag;
        end
      end
      e_seq_set_tag: begin
        lce_cmd_v_o = lce_cmd_ready_i;
        // Directory and LRU commit with the set-tag transfer
        if (lce_cmd_ready_i) begin
          wr_v_o  = 1'b1;
          state_n = e_seq_idle;
        end
      end
      default: begin
        state_n = e_seq_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= e_seq_idle;
      inv_pend_r <= '0;
    end else begin
      state_r    <= state_n;
      inv_pend_r <= inv_pend_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      req_lce_r  <= lce_req_lce_i;
      req_addr_r <= {lce_req_addr_i[paddr_width_lp-1:block_offset_lp], {block_offset_lp{1'b0}}};
      req_type_r <= lce_req_type_i;
    end
    if (state_r == e_seq_lookup) begin
      way_r        <= gad_way_i;
      next_state_r <= gad_next_state_i;
      inv_r        <= gad_inv_i;
      inv_way_r    <= gad_inv_way_i;
      wb_r         <= gad_wb_i;
      wb_addr_r    <= gad_wb_addr_i;
      mem_rd_r     <= gad_mem_rd_i;
    end
  end

  // Directory and LRU lookup starts with the accepted request
  assign rd_v_o   = lce_req_yumi_o;
  assign rd_set_o = lce_req_addr_i[block_offset_lp +: lg_sets_lp];

  assign wr_set_o     = req_addr_r[block_offset_lp +: lg_sets_lp];
  assign wr_way_o     = way_r;
  assign wr_state_o   = next_state_r;
  assign wr_inv_o     = inv_r;
  assign wr_inv_way_o = inv_way_r;

  assign lce_cmd_addr_o = req_addr_r;
  assign mem_cmd_lce_o  = req_lce_r;

  assign req_lce_o  = req_lce_r;
  assign req_tag_o  = req_addr_r[paddr_width_lp-1 -: tag_width_lp];
  assign req_type_o = req_type_r;

endmodule

//--- hdl/cce_top.sv
`timescale 1ns/1ns

module cce_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   lce_req_v_i,
  input  cce_pkg::lce_id_t       lce_req_lce_i,
  input  cce_pkg::paddr_t        lce_req_addr_i,
  input  cce_pkg::req_type_e     lce_req_type_i,
  output logic                   lce_req_yumi_o,
  output logic                   lce_cmd_v_o,
  input  logic                   lce_cmd_ready_i,
  output cce_pkg::lce_id_t       lce_cmd_dst_o,
  output cce_pkg::lce_cmd_type_e lce_cmd_type_o,
  output cce_pkg::paddr_t        lce_cmd_addr_o,
  output cce_pkg::way_t          lce_cmd_way_o,
  output cce_pkg::coh_state_e    lce_cmd_state_o,
  output logic                   mem_cmd_v_o,
  input  logic                   mem_cmd_ready_i,
  output cce_pkg::mem_cmd_type_e mem_cmd_type_o,
  output cce_pkg::paddr_t        mem_cmd_addr_o,
  output cce_pkg::lce_id_t       mem_cmd_lce_o,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_yumi_o
);
  import cce_pkg::*;

  // Directory and LRU results
  tag_t [num_lce_lp-1:0][lce_assoc_lp-1:0]       dir_tags;
  coh_state_e [num_lce_lp-1:0][lce_assoc_lp-1:0] dir_states;
  way_t                                          lru_victim;

  // Gather decision
  way_t                  gad_way;
  coh_state_e            gad_next_state;
  lce_vec_t              gad_inv;
  way_t [num_lce_lp-1:0] gad_inv_way;
  logic                  gad_wb;
  paddr_t                gad_wb_addr;
  logic                  gad_mem_rd;

  // Sequencer controls
  logic                  rd_v;
  set_t                  rd_set;
  logic                  wr_v;
  set_t                  wr_set;
  way_t                  wr_way;
  coh_state_e            wr_state;
  lce_vec_t              wr_inv;
  way_t [num_lce_lp-1:0] wr_inv_way;
  lce_id_t               req_lce;
  tag_t                  req_tag;
  req_type_e             req_type;

  cce_dir directory (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rd_v_i     (rd_v),
    .set_i      (rd_set),
    .wr_v_i     (wr_v),
    .wr_set_i   (wr_set),
    .wr_lce_i   (req_lce),
    .wr_way_i   (wr_way),
    .wr_tag_i   (req_tag),
    .wr_state_i (wr_state),
    .inv_v_i    (wr_inv),
    .inv_way_i  (wr_inv_way),
    .tags_o     (dir_tags),
    .states_o   (dir_states)
  );

  cce_lru lru (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .rd_v_i   (rd_v),
    .lce_i    (lce_req_lce_i),
    .set_i    (rd_set),
    .wr_v_i   (wr_v),
    .wr_lce_i (req_lce),
    .wr_set_i (wr_set),
    .wr_way_i (wr_way),
    .victim_o (lru_victim)
  );

  cce_gad gad (
    .req_lce_i    (req_lce),
    .req_set_i    (wr_set),
    .req_tag_i    (req_tag),
    .req_type_i   (req_type),
    .tags_i       (dir_tags),
    .states_i     (dir_states),
    .victim_i     (lru_victim),
    .way_o        (gad_way),
    .next_state_o (gad_next_state),
    .inv_o        (gad_inv),
    .inv_way_o    (gad_inv_way),
    .wb_o         (gad_wb),
    .wb_addr_o    (gad_wb_addr),
    .mem_rd_o     (gad_mem_rd)
  );

  cce_seq seq (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .lce_req_v_i      (lce_req_v_i),
    .lce_req_lce_i    (lce_req_lce_i),
    .lce_req_addr_i   (lce_req_addr_i),
    .lce_req_type_i   (lce_req_type_i),
    .lce_req_yumi_o   (lce_req_yumi_o),
    .lce_cmd_v_o      (lce_cmd_v_o),
    .lce_cmd_ready_i  (lce_cmd_ready_i),
    .lce_cmd_dst_o    (lce_cmd_dst_o),
    .lce_cmd_type_o   (lce_cmd_type_o),
    .lce_cmd_addr_o   (lce_cmd_addr_o),
    .lce_cmd_way_o    (lce_cmd_way_o),
    .lce_cmd_state_o  (lce_cmd_state_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_cmd_type_o   (mem_cmd_type_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_lce_o    (mem_cmd_lce_o),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_yumi_o  (mem_resp_yumi_o),
    .gad_way_i        (gad_way),
    .gad_next_state_i (gad_next_state),
    .gad_inv_i        (gad_inv),
    .gad_inv_way_i    (gad_inv_way),
    .gad_wb_i         (gad_wb),
    .gad_wb_addr_i    (gad_wb_addr),
    .gad_mem_rd_i     (gad_mem_rd),
    .rd_v_o           (rd_v),
    .rd_set_o         (rd_set),
    .wr_v_o           (wr_v),
    .wr_set_o         (wr_set),
    .wr_way_o         (wr_way),
    .wr_state_o       (wr_state),
    .wr_inv_o         (wr_inv),
    .wr_inv_way_o     (wr_inv_way),
    .req_lce_o        (req_lce),
    .req_tag_o        (req_tag),
    .req_type_o       (req_type)
  );

endmodule

//--- sim/cce_tb.sv
`timescale 1ns/1ns

module cce_tb;
  import cce_pkg::*;

  localparam int num_req_lp = 20;

  typedef struct packed {
    logic       is_mem;
    lce_id_t    lce;
    logic       typ;
    paddr_t     addr;
    way_t       way;
    coh_state_e state;
  } cmd_rec_t;

  logic clk_i;
  logic arst_n_i;
  logic lce_req_v_i;
  lce_id_t lce_req_lce_i;
  paddr_t lce_req_addr_i;
  req_type_e lce_req_type_i;
  logic lce_req_yumi_o;
  logic lce_cmd_v_o;
  logic lce_cmd_ready_i;
  lce_id_t lce_cmd_dst_o;
  lce_cmd_type_e lce_cmd_type_o;
  paddr_t lce_cmd_addr_o;
  way_t lce_cmd_way_o;
  coh_state_e lce_cmd_state_o;
  logic mem_cmd_v_o;
  logic mem_cmd_ready_i;
  mem_cmd_type_e mem_cmd_type_o;
  paddr_t mem_cmd_addr_o;
  lce_id_t mem_cmd_lce_o;
  logic mem_resp_v_i;
  logic mem_resp_yumi_o;

  // Reference directory and LRU
  coh_state_e ref_state [num_lce_lp][lce_sets_lp][lce_assoc_lp];
  tag_t       ref_tag [num_lce_lp][lce_sets_lp][lce_assoc_lp];
  way_t       ref_victim [num_lce_lp][lce_sets_lp];

  cmd_rec_t cmd_q [$];
  int       errors = 0;
  int       checks = 0;
  int       yumi_cnt = 0;
  int       delay_sum = 0;
  int       cycles = 0;
  int       resp_wait = 0;
  logic     resp_pend = 1'b0;
  logic     bp_mode = 1'b0;

  cce_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic compare_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  task automatic next_cmd(output cmd_rec_t rec);
    while (cmd_q.size() == 0) begin
      @(posedge clk_i);
    end
    rec = cmd_q.pop_front();
  endtask

  task automatic check_lce_cmd(input lce_id_t dst, input lce_cmd_type_e typ, input paddr_t addr,
                               input way_t way, input coh_state_e st);
    cmd_rec_t rec;
    next_cmd(rec);
    if (rec.is_mem) begin
      errors++;
      $display("Expected an LCE command but a memory command came first");
      return;
    end
    compare_hex("lce_cmd_dst_o", dst, rec.lce);
    compare_hex("lce_cmd_type_o", typ, rec.typ);
    compare_hex("lce_cmd_addr_o", addr, rec.addr);
    compare_hex("lce_cmd_way_o", way, rec.way);
    compare_hex("lce_cmd_state_o", st, rec.state);
  endtask

  task automatic check_mem_cmd(input mem_cmd_type_e typ, input paddr_t addr, input lce_id_t lce);
    cmd_rec_t rec;
    next_cmd(rec);
    if (!rec.is_mem) begin
      errors++;
      $display("Expected a memory command but an LCE command came first");
      return;
    end
    compare_hex("mem_cmd_type_o", typ, rec.typ);
    compare_hex("mem_cmd_addr_o", addr, rec.addr);
    compare_hex("mem_cmd_lce_o", lce, rec.lce);
  endtask

  // Drives one request and checks it against the reference model
  task automatic run_request(input lce_id_t lce, input tag_t tag, input set_t set,
                             input req_type_e typ);
    paddr_t     blk;
    lce_vec_t   holds;
    lce_vec_t   owns;
    lce_vec_t   inv;
    way_t       hway [num_lce_lp];
    logic       hit;
    way_t       way;
    coh_state_e ns;
    logic       wb;
    int         yumi_before;
    blk   = {tag, set, {block_offset_lp{1'b0}}};
    holds = '0;
    owns  = '0;
    for (int l = 0; l < num_lce_lp; l++) begin
      hway[l] = '0;
      for (int w = 0; w < lce_assoc_lp; w++) begin
        if (ref_state[l][set][w] != e_coh_i && ref_tag[l][set][w] == tag) begin
          holds[l] = 1'b1;
          hway[l]  = way_t'(w);
          owns[l]  = (ref_state[l][set][w] == e_coh_e || ref_state[l][set][w] == e_coh_m);
        end
      end
    end
    hit       = holds[lce];
    way       = hit ? hway[lce] : ref_victim[lce][set];
    holds[lce] = 1'b0;
    owns[lce]  = 1'b0;
    if (typ == e_req_wr) begin
      inv = holds;
      ns  = e_coh_m;
    end else if (owns != '0) begin
      inv = owns;
      ns  = e_coh_e;
    end else if (holds != '0) begin
      inv = '0;
      ns  = e_coh_s;
    end else begin
      inv = '0;
      ns  = e_coh_e;
    end
    wb = !hit && ref_state[lce][set][way] == e_coh_m;

    if (cmd_q.size() != 0) begin
      errors++;
      $display("Commands appeared while no request was in flight");
      cmd_q.delete();
    end
    yumi_before = yumi_cnt;
    @(negedge clk_i);
    lce_req_v_i    = 1'b1;
    lce_req_lce_i  = lce;
    lce_req_addr_i = blk | paddr_t'(6'h15);
    lce_req_type_i = typ;
    #10;
    while (!lce_req_yumi_o) begin
      @(negedge clk_i);
      #10;
    end
    @(negedge clk_i);
    lce_req_v_i = 1'b0;

    for (int l = 0; l < num_lce_lp; l++) begin
      if (inv[l]) begin
        check_lce_cmd(lce_id_t'(l), e_cmd_invalidate, blk, hway[l], e_coh_i);
      end
    end
    if (wb) begin
      check_mem_cmd(e_mem_wb, {ref_tag[lce][set][way], set, {block_offset_lp{1'b0}}}, lce);
    end
    if (!(typ == e_req_wr && hit)) begin
      check_mem_cmd(e_mem_rd, blk, lce);
    end
    check_lce_cmd(lce, e_cmd_set_tag, blk, way, ns);
    if (yumi_cnt != yumi_before + 1) begin
      errors++;
      $display("Request saw %0d yumi pulses instead of one", yumi_cnt - yumi_before);
    end

    for (int l = 0; l < num_lce_lp; l++) begin
      if (inv[l]) begin
        ref_state[l][set][hway[l]] = e_coh_i;
      end
    end
    ref_state[lce][set][way] = ns;
    ref_tag[lce][set][way]   = tag;
    ref_victim[lce][set]     = ~way;
  endtask

  task automatic quiet_after_reset();
    repeat (6) begin
      @(negedge clk_i);
      #10;
      checks++;
      if (lce_req_yumi_o || lce_cmd_v_o || mem_cmd_v_o || mem_resp_yumi_o) begin
        errors++;
        $display("Handshake output went high with no request present");
      end
    end
  endtask

  task automatic read_miss_fill();
    run_request(2'd0, 22'h0a5a1, 4'd3, e_req_rd);
    run_request(2'd0, 22'h0b6b2, 4'd3, e_req_rd);
  endtask

  // Reads grant E, so a block never has more than one holder here
  task automatic read_with_owner();
    run_request(2'd1, 22'h0a5a1, 4'd3, e_req_rd);
    run_request(2'd2, 22'h0a5a1, 4'd3, e_req_rd);
  endtask

  task automatic write_invalidates();
    run_request(2'd2, 22'h0a5a1, 4'd3, e_req_wr);
    run_request(2'd0, 22'h0a5a1, 4'd3, e_req_wr);
  endtask

  // LCE0 now holds the M block in way 0 and its victim is way 1
  task automatic dirty_victim_writeback();
    run_request(2'd0, 22'h0c7c3, 4'd3, e_req_rd);
    run_request(2'd0, 22'h0d8d4, 4'd3, e_req_rd);
  endtask

  task automatic random_back_pressure();
    tag_t pool [4] = '{22'h01111, 22'h02222, 22'h03333, 22'h04444};
    bp_mode = 1'b1;
    for (int i = 0; i < 12; i++) begin
      run_request(lce_id_t'(i % 4), pool[(i * 3) % 4], (i % 2) ? set_t'(3) : set_t'(5),
                  (i % 3 == 0) ? e_req_wr : e_req_rd);
    end
    bp_mode = 1'b0;
  endtask

  // Ready drive, memory responder and handshake monitor
  initial begin : environment
    cmd_rec_t rec;
    void'($urandom(58730));
    forever begin
      @(negedge clk_i);
      lce_cmd_ready_i = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
      mem_cmd_ready_i = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
      mem_resp_v_i    = resp_pend && (resp_wait == 0);
      if (resp_pend && resp_wait > 0) begin
        resp_wait--;
      end
      #10;
      if (lce_req_yumi_o) begin
        yumi_cnt++;
        if (!lce_req_v_i) begin
          errors++;
          $display("Request yumi asserted without a valid request");
        end
      end
      if (mem_resp_yumi_o) begin
        if (!mem_resp_v_i) begin
          errors++;
          $display("Memory response yumi asserted without a valid response");
        end
        resp_pend = 1'b0;
      end
      if (lce_cmd_v_o) begin
        if (!lce_cmd_ready_i) begin
          errors++;
          $display("LCE command valid while its ready was low");
        end
        rec.is_mem = 1'b0;
        rec.lce    = lce_cmd_dst_o;
        rec.typ    = lce_cmd_type_o;
        rec.addr   = lce_cmd_addr_o;
        rec.way    = lce_cmd_way_o;
        rec.state  = lce_cmd_state_o;
        cmd_q.push_back(rec);
      end
      if (mem_cmd_v_o) begin
        if (!mem_cmd_ready_i) begin
          errors++;
          $display("Memory command valid while its ready was low");
        end
        rec.is_mem = 1'b1;
        rec.lce    = mem_cmd_lce_o;
        rec.typ    = mem_cmd_type_o;
        rec.addr   = mem_cmd_addr_o;
        rec.way    = '0;
        rec.state  = e_coh_i;
        cmd_q.push_back(rec);
        if (mem_cmd_type_o == e_mem_rd) begin
          resp_pend = 1'b1;
          resp_wait = $urandom_range(5, 0);
          delay_sum += resp_wait;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycles <= 40 * num_req_lp + delay_sum + 20) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles with a request still open", cycles);
    $display("Checks: %0d  Errors: %0d", checks, errors + 1);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    arst_n_i        = 1'b0;
    lce_req_v_i     = 1'b0;
    lce_req_lce_i   = '0;
    lce_req_addr_i  = '0;
    lce_req_type_i  = e_req_rd;
    lce_cmd_ready_i = 1'b1;
    mem_cmd_ready_i = 1'b1;
    mem_resp_v_i    = 1'b0;
    for (int l = 0; l < num_lce_lp; l++) begin
      for (int s = 0; s < lce_sets_lp; s++) begin
        ref_victim[l][s] = '0;
        for (int w = 0; w < lce_assoc_lp; w++) begin
          ref_state[l][s][w] = e_coh_i;
          ref_tag[l][s][w]   = '0;
        end
      end
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    quiet_after_reset();
    read_miss_fill();
    read_with_owner();
    write_invalidates();
    dirty_victim_writeback();
    random_back_pressure();

    repeat (3) @(negedge clk_i);
    if (cmd_q.size() != 0) begin
      errors++;
      $display("Extra commands arrived after the last request");
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- cce_top.f
hdl/cce_pkg.sv
hdl/cce_dir.sv
hdl/cce_lru.sv
hdl/cce_gad.sv
hdl/cce_seq.sv
hdl/cce_top.sv
sim/cce_tb.sv

//--- Bender.yml
package:
  name: cce_top

sources:
  - files:
      - hdl/cce_pkg.sv
      - hdl/cce_dir.sv
      - hdl/cce_lru.sv
      - hdl/cce_gad.sv
      - hdl/cce_seq.sv
      - hdl/cce_top.sv
  - target: simulation
    files:
      - sim/cce_tb.sv
